// File: pool_engine.f
+incdir+src
src/pool_pkg.sv
src/pool_cmd_regs.sv
src/pool_addr_gen.sv
src/atom_deserializer.sv
src/pool_lane_array.sv
src/result_writer.sv
src/pool_engine.sv
verification/pool_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pool engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pool_engine_tb \
	-f pool_engine.f --Mdir obj_dir -o pool_engine_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/pool_engine_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1

// File: verification/pool_engine_tb.sv
`timescale 1ns/1ns
`include "pool_engine_cfg.svh"

module pool_engine_tb;
	localparam int LANES        = `POOL_BURST_LEN;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES  = 10;
	localparam int BUSY_WAIT    = 20;  // Cycles into a command before the stray strobe
	localparam int GAP_BITS     = 1;   // Normal DMA gaps of 0 or 1 cycle
	localparam int BP_GAP_BITS  = 4;   // Back-pressure gaps of up to 15 cycles
	localparam pool_pkg::addr_t DATA_BASE = 30'h0001_2340;
	localparam int DATA_WORDS = 25 * LANES;  // Largest map is 5 x 5 atoms
	localparam pool_pkg::addr_t RES_BASE = 30'h0200_0000;
	// Test geometries
	localparam int MAXP_K    = 2;
	localparam int MAXP_S    = 2;
	localparam int MAXP_SIDE = 4;
	localparam int AVEP_K    = 3;
	localparam int AVEP_S    = 1;
	localparam int AVEP_SIDE = 5;
	localparam int BP_K      = 2;
	localparam int BP_S      = 1;
	localparam int BP_SIDE   = 3;

	logic              clk;
	logic              rst;
	logic              i_engine_valid;
	pool_pkg::op_t     i_op_type;
	pool_pkg::side_t   i_kernel;
	pool_pkg::side_t   i_stride;
	pool_pkg::side_t   i_i_side;
	pool_pkg::side_t   i_o_side;
	pool_pkg::addr_t   i_data_start_addr;
	pool_pkg::addr_t   i_result_start_addr;
	logic              o_engine_ready;
	logic              o_rd_en;
	pool_pkg::addr_t   o_rd_addr;
	logic              i_rd_we;
	pool_pkg::sample_t i_rd_data;
	logic              o_wr_en;
	pool_pkg::addr_t   o_wr_addr;
	pool_pkg::sample_t o_wr_data;
	logic              o_wr_valid;
	logic              i_wr_re;

	pool_pkg::sample_t mem [pool_pkg::addr_t];  // Input feature maps
	pool_pkg::sample_t got [pool_pkg::addr_t];  // Words written by the DUT
	logic [31:0]       lfsr;
	int                rd_gap_bits;
	int                wr_gap_bits;
	pool_pkg::op_t     cur_op;     // Command now running
	int                cur_k;
	int                cur_s;
	int                cur_i;
	int                cur_o;
	pool_pkg::addr_t   cur_data;
	pool_pkg::addr_t   cur_res;
	int                rd_seen;    // Bursts served for this command
	int                pix_seen;   // Result pixels started
	int                wr_words;
	int                errors;
	int                tests;
	int                failed;
	logic              re_q = 1'b0;

	pool_engine pool_engine_inst (.*);

	always #10 clk = ~clk;

	// Galois form with right shift
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);  // One step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// Atom at (row, col) of a map that is side atoms wide
	function automatic pool_pkg::addr_t atom_addr(input pool_pkg::addr_t base, input int row,
		input int col, input int side);
		return base + pool_pkg::addr_t'((row * side + col) * LANES);
	endfunction

	// Window of pixel (y, x) is read row-major with one atom per burst
	function automatic pool_pkg::addr_t exp_rd_addr(input int n);
		int p;
		int w;
		p = n / (cur_k * cur_k);
		w = n % (cur_k * cur_k);
		return atom_addr(cur_data, (p / cur_o) * cur_s + w / cur_k,
			(p % cur_o) * cur_s + w % cur_k, cur_i);
	endfunction

	function automatic pool_pkg::sample_t pool_ref(input int y, input int x, input int lane);
		int acc;
		int v;
		acc = 0;
		for (int r = 0; r < cur_k; r++) begin
			for (int c = 0; c < cur_k; c++) begin
				v = int'(mem[atom_addr(cur_data, y * cur_s + r, x * cur_s + c, cur_i) +
					pool_pkg::addr_t'(lane)]);
				if (cur_op == pool_pkg::OP_AVEPOOL)
					acc += v;
				else if (v > acc)
					acc = v;
			end
		end
		if (cur_op == pool_pkg::OP_AVEPOOL)
			acc = acc / (cur_k * cur_k);  // Floor since all values are positive
		return pool_pkg::sample_t'(acc);
	endfunction

	// Worst case cycles of one command with every gap at its maximum
	function automatic int budget(input int k, input int s, input int side, input bit ave,
		input int gap_bits);
		int o_side;
		int burst;
		o_side = (side - k) / s + 1;
		burst  = LANES * (1 << gap_bits) + 8;
		return o_side * o_side * (k * k * burst + burst + (ave ? LANES * `POOL_ACC_W + 4 : 4));
	endfunction

	task automatic check_sample(input pool_pkg::sample_t act, input pool_pkg::sample_t exp,
		input string what);
		if (act !== exp) begin
			errors++;
			$display("error %0t: %s is %h, expected %h", $time, what, act, exp);
		end
	endtask

	task automatic check_addr(input pool_pkg::addr_t act, input pool_pkg::addr_t exp,
		input string what);
		if (act !== exp) begin
			errors++;
			$display("error %0t: %s is %h, expected %h", $time, what, act, exp);
		end
	endtask

	task automatic check_flag(input logic act, input logic exp, input string what);
		if (act !== exp) begin
			errors++;
			$display("error %0t: %s is %b, expected %b", $time, what, act, exp);
		end
	endtask

	// DMA read side answers each request with one burst
	initial begin : read_dma
		pool_pkg::addr_t base;
		int              gap;
		i_rd_we   = 1'b0;
		i_rd_data = '0;
		forever begin
			@(negedge clk);
			if (o_rd_en === 1'b1) begin
				base = o_rd_addr;
				check_addr(base, exp_rd_addr(rd_seen), $sformatf("o_rd_addr of burst %0d", rd_seen));
				rd_seen++;
				for (int l = 0; l < LANES; l++) begin
					draw_bits(rd_gap_bits, gap);
					repeat (gap) @(negedge clk);
					if (!mem.exists(base + pool_pkg::addr_t'(l))) begin
						errors++;
						$display("Read burst at %h runs outside the input feature map", base);
					end
					i_rd_we   = 1'b1;
					i_rd_data = mem.exists(base + pool_pkg::addr_t'(l)) ?
						mem[base + pool_pkg::addr_t'(l)] : '0;
					@(negedge clk);
					i_rd_we = 1'b0;
				end
			end
		end
	end

	// DMA write side pulls one lane per i_wr_re
	initial begin : write_dma
		pool_pkg::addr_t base;
		int              gap;
		i_wr_re = 1'b0;
		forever begin
			@(negedge clk);
			if (o_wr_en === 1'b1) begin
				base = o_wr_addr;
				check_addr(base, atom_addr(cur_res, pix_seen / cur_o, pix_seen % cur_o, cur_o),
					$sformatf("o_wr_addr of pixel %0d", pix_seen));
				pix_seen++;
				for (int l = 0; l < LANES; l++) begin
					draw_bits(wr_gap_bits, gap);
					repeat (gap) @(negedge clk);
					i_wr_re = 1'b1;
					@(negedge clk);
					i_wr_re = 1'b0;
					if (l == 0)
						check_flag(o_wr_en, 1'b0, "o_wr_en after first i_wr_re");
					got[base + pool_pkg::addr_t'(l)] = o_wr_data;  // Data of the strobe just given
					wr_words++;
				end
			end
		end
	end

	always @(posedge clk) re_q <= i_wr_re;  // Strobe as the DUT saw it

	always @(negedge clk) begin
		if (!rst)
			check_flag(o_wr_valid, re_q, "o_wr_valid one cycle after i_wr_re");
	end

	// Pulse i_engine_valid once with a full command
	task automatic drive_command(input pool_pkg::op_t op, input int k, input int s, input int side,
		input pool_pkg::addr_t data, input pool_pkg::addr_t res);
		i_op_type           = op;
		i_kernel            = pool_pkg::side_t'(k);
		i_stride            = pool_pkg::side_t'(s);
		i_i_side            = pool_pkg::side_t'(side);
		i_o_side            = pool_pkg::side_t'((side - k) / s + 1);
		i_data_start_addr   = data;
		i_result_start_addr = res;
		i_engine_valid      = 1'b1;
		@(negedge clk);
		i_engine_valid = 1'b0;
	endtask

	task automatic start_command(input pool_pkg::op_t op, input int k, input int s, input int side,
		input pool_pkg::addr_t data, input pool_pkg::addr_t res);
		cur_op   = op;
		cur_k    = k;
		cur_s    = s;
		cur_i    = side;
		cur_o    = (side - k) / s + 1;
		cur_data = data;
		cur_res  = res;
		rd_seen  = 0;
		pix_seen = 0;
		wr_words = 0;
		got.delete();
		drive_command(op, k, s, side, data, res);
		check_flag(o_engine_ready, 1'b0, "o_engine_ready after accept");
	endtask

	// Wait for o_engine_ready and compare every result word
	task automatic finish_command();
		pool_pkg::addr_t a;
		while (o_engine_ready !== 1'b1)
			@(negedge clk);
		if (wr_words != cur_o * cur_o * LANES) begin
			errors++;
			$display("Command wrote %0d result words instead of %0d", wr_words, cur_o * cur_o * LANES);
		end
		for (int y = 0; y < cur_o; y++) begin
			for (int x = 0; x < cur_o; x++) begin
				for (int l = 0; l < LANES; l++) begin
					a = atom_addr(cur_res, y, x, cur_o) + pool_pkg::addr_t'(l);
					if (!got.exists(a)) begin
						errors++;
						$display("No result word was written at address %h", a);
					end else
						check_sample(got[a], pool_ref(y, x, l),
							$sformatf("pixel (%0d,%0d) lane %0d", y, x, l));
				end
			end
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		if (errors != errs_before)
			failed++;
		$display("Test %0d %s: %s", tests, name, (errors == errs_before) ? "passed" : "failed");
	endtask

	task automatic test_idle();
		int e0;
		e0 = errors;
		for (int c = 0; c < IDLE_CYCLES; c++) begin
			check_flag(o_rd_en, 1'b0, "o_rd_en while idle");
			check_flag(o_wr_en, 1'b0, "o_wr_en while idle");
			check_flag(o_wr_valid, 1'b0, "o_wr_valid while idle");
			check_flag(o_engine_ready, 1'b0, "o_engine_ready while idle");
			@(negedge clk);
		end
		end_test("idle after reset", e0);
	endtask

	task automatic test_maxpool();
		int e0;
		e0 = errors;
		rd_gap_bits = GAP_BITS;
		wr_gap_bits = GAP_BITS;
		start_command(pool_pkg::OP_MAXPOOL, MAXP_K, MAXP_S, MAXP_SIDE, DATA_BASE, RES_BASE);
		finish_command();
		end_test("maxpool k2 s2", e0);
	endtask

	task automatic test_avepool();
		int e0;
		e0 = errors;
		start_command(pool_pkg::OP_AVEPOOL, AVEP_K, AVEP_S, AVEP_SIDE, DATA_BASE,
			RES_BASE + 30'h1000);
		finish_command();
		end_test("avepool k3 s1", e0);
	endtask

	task automatic test_backpressure();
		int e0;
		e0 = errors;
		rd_gap_bits = BP_GAP_BITS;  // Long stalls on both DMA sides
		wr_gap_bits = BP_GAP_BITS;
		start_command(pool_pkg::OP_AVEPOOL, BP_K, BP_S, BP_SIDE, DATA_BASE + 30'd16,
			RES_BASE + 30'h2000);
		finish_command();
		rd_gap_bits = GAP_BITS;
		wr_gap_bits = GAP_BITS;
		end_test("back-pressure", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		e0 = errors;
		start_command(pool_pkg::OP_MAXPOOL, MAXP_K, MAXP_S, MAXP_SIDE, DATA_BASE,
			RES_BASE + 30'h3000);
		repeat (BUSY_WAIT) @(negedge clk);
		// Strobe while busy must leave no trace
		drive_command(pool_pkg::OP_AVEPOOL, AVEP_K, AVEP_S, AVEP_SIDE, DATA_BASE,
			RES_BASE + 30'h4000);
		check_flag(o_engine_ready, 1'b0, "o_engine_ready after strobe while busy");
		finish_command();
		// A kept strobe would start a second command here
		for (int c = 0; c < IDLE_CYCLES; c++) begin
			check_flag(o_rd_en, 1'b0, "o_rd_en after the strobe while busy");
			check_flag(o_engine_ready, 1'b1, "o_engine_ready after the first command");
			@(negedge clk);
		end
		start_command(pool_pkg::OP_AVEPOOL, MAXP_K, MAXP_S, MAXP_SIDE, DATA_BASE + 30'd144,
			RES_BASE + 30'h5000);
		finish_command();
		end_test("back to back", e0);
	endtask

	initial begin : watchdog
		int limit;
		int cycle_count;
		limit = 2 * (RESET_CYCLES + 2 * IDLE_CYCLES + BUSY_WAIT +
			budget(MAXP_K, MAXP_S, MAXP_SIDE, 1'b0, GAP_BITS) +
			budget(AVEP_K, AVEP_S, AVEP_SIDE, 1'b1, GAP_BITS) +
			budget(BP_K, BP_S, BP_SIDE, 1'b1, BP_GAP_BITS) +
			budget(MAXP_K, MAXP_S, MAXP_SIDE, 1'b0, GAP_BITS) +
			budget(MAXP_K, MAXP_S, MAXP_SIDE, 1'b1, GAP_BITS));
		cycle_count = 0;
		while (cycle_count < limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", limit);
		$display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin : main
		int v;
		clk                 = 1'b0;
		rst                 = 1'b1;
		i_engine_valid      = 1'b0;
		i_op_type           = pool_pkg::OP_MAXPOOL;
		i_kernel            = '0;
		i_stride            = '0;
		i_i_side            = '0;
		i_o_side            = '0;
		i_data_start_addr   = '0;
		i_result_start_addr = '0;
		rd_gap_bits         = GAP_BITS;
		wr_gap_bits         = GAP_BITS;
		errors              = 0;
		tests               = 0;
		failed              = 0;
		lfsr                = 32'h2ef30bb6;
		for (int a = 0; a < DATA_WORDS; a++) begin
			draw_bits(`POOL_SAMPLE_W, v);
			mem[DATA_BASE + pool_pkg::addr_t'(a)] = pool_pkg::sample_t'(v);
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		test_idle();
		test_maxpool();
		test_avepool();
		test_backpressure();
		test_back_to_back();
		$display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: src/pool_engine.sv
`timescale 1ns/1ns

module pool_engine (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_engine_valid,
	input  pool_pkg::op_t     i_op_type,
	input  pool_pkg::side_t   i_kernel,
	input  pool_pkg::side_t   i_stride,
	input  pool_pkg::side_t   i_i_side,
	input  pool_pkg::side_t   i_o_side,
	input  pool_pkg::addr_t   i_data_start_addr,
	input  pool_pkg::addr_t   i_result_start_addr,
	output logic              o_engine_ready,
	output logic              o_rd_en,
	output pool_pkg::addr_t   o_rd_addr,
	input  logic              i_rd_we,
	input  pool_pkg::sample_t i_rd_data,
	output logic              o_wr_en,
	output pool_pkg::addr_t   o_wr_addr,
	output pool_pkg::sample_t o_wr_data,
	output logic              o_wr_valid,
	input  logic              i_wr_re
);
	logic                start;
	pool_pkg::op_t       op;
	pool_pkg::side_t     kernel;
	pool_pkg::side_t     stride;
	pool_pkg::side_t     i_side;
	pool_pkg::side_t     o_side;
	pool_pkg::addr_t     data_start;
	pool_pkg::addr_t     result_start;
	pool_pkg::side_t     window_count;
	logic                cmd_done;
	pool_pkg::addr_t     pix_wr_addr;   // Result address of pixel in flight
	logic                window_first;
	logic                window_last;
	logic                last_pixel;
	logic                pixel_done;
	pool_pkg::atom_t     atom;
	logic                atom_valid;
	pool_pkg::acc_atom_t pool;
	logic                pool_valid;

	pool_cmd_regs pool_cmd_regs_inst (
		.clk                 (clk),
		.rst                 (rst),
		.i_engine_valid      (i_engine_valid),
		.i_op_type           (i_op_type),
		.i_kernel            (i_kernel),
		.i_stride            (i_stride),
		.i_i_side            (i_i_side),
		.i_o_side            (i_o_side),
		.i_data_start_addr   (i_data_start_addr),
		.i_result_start_addr (i_result_start_addr),
		.i_cmd_done          (cmd_done),
		.o_start             (start),
		.o_op                (op),
		.o_kernel            (kernel),
		.o_stride            (stride),
		.o_i_side            (i_side),
		.o_o_side            (o_side),
		.o_data_start        (data_start),
		.o_result_start      (result_start),
		.o_window_count      (window_count),
		.o_engine_ready      (o_engine_ready)
	);

	pool_addr_gen pool_addr_gen_inst (
		.clk            (clk),
		.rst            (rst),
		.i_start        (start),
		.i_kernel       (kernel),
		.i_stride       (stride),
		.i_i_side       (i_side),
		.i_o_side       (o_side),
		.i_data_start   (data_start),
		.i_result_start (result_start),
		.i_atom_valid   (atom_valid),
		.i_pixel_done   (pixel_done),
		.o_rd_en        (o_rd_en),
		.o_rd_addr      (o_rd_addr),
		.o_wr_addr      (pix_wr_addr),
		.o_window_first (window_first),
		.o_window_last  (window_last),
		.o_last_pixel   (last_pixel)
	);

	atom_deserializer atom_deserializer_inst (
		.clk          (clk),
		.rst          (rst),
		.i_rd_we      (i_rd_we),
		.i_rd_data    (i_rd_data),
		.o_atom       (atom),
		.o_atom_valid (atom_valid)
	);

	pool_lane_array pool_lane_array_inst (
		.clk            (clk),
		.rst            (rst),
		.i_op           (op),
		.i_atom         (atom),
		.i_atom_valid   (atom_valid),
		.i_window_first (window_first),
		.i_window_last  (window_last),
		.o_pool         (pool),
		.o_pool_valid   (pool_valid)
	);

	result_writer result_writer_inst (
		.clk            (clk),
		.rst            (rst),
		.i_op           (op),
		.i_window_count (window_count),
		.i_pool         (pool),
		.i_pool_valid   (pool_valid),
		.i_wr_addr      (pix_wr_addr),
		.i_last_pixel   (last_pixel),
		.i_wr_re        (i_wr_re),
		.o_wr_en        (o_wr_en),
		.o_wr_addr      (o_wr_addr),
		.o_wr_data      (o_wr_data),
		.o_wr_valid     (o_wr_valid),
		.o_pixel_done   (pixel_done),
		.o_cmd_done     (cmd_done)
	);

endmodule

// File: src/result_writer.sv
`timescale 1ns/1ns
`include "pool_engine_cfg.svh"

module result_writer (
	input  logic                clk,
	input  logic                rst,
	input  pool_pkg::op_t       i_op,
	input  pool_pkg::side_t     i_window_count,
	input  pool_pkg::acc_atom_t i_pool,
	input  logic                i_pool_valid,
	input  pool_pkg::addr_t     i_wr_addr,
	input  logic                i_last_pixel,
	input  logic                i_wr_re,
	output logic                o_wr_en,
	output pool_pkg::addr_t     o_wr_addr,
	output pool_pkg::sample_t   o_wr_data,
	output logic                o_wr_valid,
	output logic                o_pixel_done,
	output logic                o_cmd_done
);
	localparam int ACC_W  = `POOL_ACC_W;
	localparam int LANE_W = $clog2(`POOL_BURST_LEN);
	localparam int STEP_W = $clog2(ACC_W);
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`POOL_BURST_LEN - 1);
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(ACC_W - 1);

	typedef enum logic [1:0] {st_idle, st_div, st_send, st_fin} state_t;
	typedef logic [ACC_W:0] wide_t;

	state_t              state;
	logic [LANE_W-1:0]   div_lane;   // Lane being divided
	logic [LANE_W-1:0]   wr_lane;    // Next lane to send
	logic [STEP_W-1:0]   step;       // Divider bit position
	pool_pkg::acc_atom_t pool_buf;
	pool_pkg::atom_t     res;        // Final samples of the pixel
	pool_pkg::acc_t      quo;        // Dividend in, quotient out
	pool_pkg::acc_t      rem;
	wide_t               rem_sh;
	wide_t               divisor;
	logic                fits;
	pool_pkg::acc_t      rem_next;
	pool_pkg::acc_t      quo_next;

	// Restoring divider, one quotient bit per cycle
	assign divisor  = wide_t'(i_window_count);
	assign rem_sh   = {rem, quo[ACC_W-1]};
	assign fits     = (rem_sh >= divisor);
	assign rem_next = fits ? pool_pkg::acc_t'(rem_sh - divisor) : pool_pkg::acc_t'(rem_sh);
	assign quo_next = {quo[ACC_W-2:0], fits};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= st_idle;
			o_wr_en      <= 1'b0;
			o_wr_valid   <= 1'b0;
			o_pixel_done <= 1'b0;
			o_cmd_done   <= 1'b0;
			div_lane     <= '0;
			wr_lane      <= '0;
			step         <= '0;
		end else begin
			o_wr_valid   <= 1'b0;
			o_pixel_done <= 1'b0;
			o_cmd_done   <= 1'b0;
			case (state)
				st_idle: if (i_pool_valid) begin
					div_lane <= '0;
					wr_lane  <= '0;
					step     <= '0;
					if (i_op == pool_pkg::OP_AVEPOOL) begin
						state <= st_div;
					end else begin
						state   <= st_send;
						o_wr_en <= 1'b1;  // Maxpool goes straight out
					end
				end
				st_div: begin
					step <= step + 1'b1;
					if (step == LAST_STEP) begin
						step     <= '0;
						div_lane <= div_lane + 1'b1;
						if (div_lane == LAST_LANE) begin
							state   <= st_send;
							o_wr_en <= 1'b1;
						end
					end
				end
				st_send: if (i_wr_re) begin
					o_wr_en    <= 1'b0;  // Burst accepted by DMA
					o_wr_valid <= 1'b1;
					wr_lane    <= wr_lane + 1'b1;
					if (wr_lane == LAST_LANE)
						state <= st_fin;
				end
				st_fin: begin
					o_pixel_done <= 1'b1;
					o_cmd_done   <= i_last_pixel;
					state        <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			st_idle: if (i_pool_valid) begin
				pool_buf  <= i_pool;
				o_wr_addr <= i_wr_addr;
				quo       <= i_pool[0];
				rem       <= '0;
				for (int l = 0; l < `POOL_BURST_LEN; l++)
					res[l] <= pool_pkg::sample_t'(i_pool[l]);  // Lane max fits a sample
			end
			st_div: if (step == LAST_STEP) begin
				res[div_lane] <= pool_pkg::sample_t'(quo_next);
				quo           <= pool_buf[div_lane + 1'b1];  // Load next lane
				rem           <= '0;
			end else begin
				quo <= quo_next;
				rem <= rem_next;
			end
			st_send: if (i_wr_re)
				o_wr_data <= res[wr_lane];
			default: ;
		endcase
	end

	// Walker must hold the next window until o_pixel_done
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		i_pool_valid |-> (state == st_idle));

endmodule

// File: src/pool_lane_array.sv
`timescale 1ns/1ns
`include "pool_engine_cfg.svh"

module pool_lane_array (
	input  logic                clk,
	input  logic                rst,
	input  pool_pkg::op_t       i_op,
	input  pool_pkg::atom_t     i_atom,
	input  logic                i_atom_valid,
	input  logic                i_window_first,
	input  logic                i_window_last,
	output pool_pkg::acc_atom_t o_pool,
	output logic                o_pool_valid
);
	logic win_open;  // Window started, result not yet out

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_pool_valid <= 1'b0;
			win_open     <= 1'b0;
		end else begin
			o_pool_valid <= i_atom_valid && i_window_last;  // Result sits in o_pool
			if (i_atom_valid) begin
				if (i_window_last)
					win_open <= 1'b0;
				else if (i_window_first)
					win_open <= 1'b1;
			end
		end
	end

	// One reducer per lane, all lanes in step
	always_ff @(posedge clk) begin
		if (i_atom_valid) begin
			for (int l = 0; l < `POOL_BURST_LEN; l++) begin
				if (i_window_first)
					o_pool[l] <= pool_pkg::acc_t'(i_atom[l]);  // Fresh window
				else if (i_op == pool_pkg::OP_AVEPOOL)
					o_pool[l] <= o_pool[l] + pool_pkg::acc_t'(i_atom[l]);
				else if (pool_pkg::acc_t'(i_atom[l]) > o_pool[l])
					o_pool[l] <= pool_pkg::acc_t'(i_atom[l]);  // Keep the larger
			end
		end
	end

	// Window ordering from the walker
	a_first_before_last: assert property (@(posedge clk) disable iff (rst)
		(i_atom_valid && i_window_last) |-> (win_open || i_window_first));

endmodule

// File: src/atom_deserializer.sv
`timescale 1ns/1ns
`include "pool_engine_cfg.svh"

module atom_deserializer (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_rd_we,
	input  pool_pkg::sample_t i_rd_data,
	output pool_pkg::atom_t   o_atom,
	output logic              o_atom_valid
);
	localparam int CNT_W = $clog2(`POOL_BURST_LEN);
	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`POOL_BURST_LEN - 1);

	logic [CNT_W-1:0] word_cnt;  // Words of current burst seen

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= i_rd_we && (word_cnt == LAST_WORD);
			if (i_rd_we) begin
				if (word_cnt == LAST_WORD)
					word_cnt <= '0;
				else
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// New word enters the top lane, lane 0 ends at the bottom
	always_ff @(posedge clk) begin
		if (i_rd_we)
			o_atom <= {i_rd_data, o_atom[`POOL_BURST_LEN-1:1]};
	end

endmodule

// File: src/pool_addr_gen.sv
`timescale 1ns/1ns
`include "pool_engine_cfg.svh"

module pool_addr_gen (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_start,
	input  pool_pkg::side_t i_kernel,
	input  pool_pkg::side_t i_stride,
	input  pool_pkg::side_t i_i_side,
	input  pool_pkg::side_t i_o_side,
	input  pool_pkg::addr_t i_data_start,
	input  pool_pkg::addr_t i_result_start,
	input  logic            i_atom_valid,
	input  logic            i_pixel_done,
	output logic            o_rd_en,
	output pool_pkg::addr_t o_rd_addr,
	output pool_pkg::addr_t o_wr_addr,
	output logic            o_window_first,
	output logic            o_window_last,
	output logic            o_last_pixel
);
	localparam pool_pkg::addr_t ATOM_WORDS = pool_pkg::addr_t'(`POOL_BURST_LEN);

	typedef enum logic [1:0] {st_idle, st_req, st_wait_atom, st_wait_pix} state_t;

	state_t          state;
	pool_pkg::side_t oy;         // Output row
	pool_pkg::side_t ox;         // Output column
	pool_pkg::side_t wy;         // Row inside window
	pool_pkg::side_t wx;         // Column inside window
	pool_pkg::addr_t row_base;   // First window of current output row
	pool_pkg::addr_t win_base;   // Top-left atom of current window
	pool_pkg::addr_t rd_ptr;     // Next atom to fetch
	pool_pkg::addr_t col_step;
	pool_pkg::addr_t row_step;
	pool_pkg::addr_t line_jump;
	logic            rd_outstanding;

	assign col_step = pool_pkg::addr_t'(i_stride) * ATOM_WORDS;
	assign row_step = pool_pkg::addr_t'(i_stride) * pool_pkg::addr_t'(i_i_side) * ATOM_WORDS;
	// End of a window row to start of the next, skipping i_side - kernel atoms
	assign line_jump = (pool_pkg::addr_t'(i_i_side) - pool_pkg::addr_t'(i_kernel) + 1'b1) *
		ATOM_WORDS;

	assign o_window_first = (wy == '0) && (wx == '0);
	assign o_window_last  = (wy == i_kernel - 1'b1) && (wx == i_kernel - 1'b1);
	assign o_last_pixel   = (oy == i_o_side - 1'b1) && (ox == i_o_side - 1'b1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state          <= st_idle;
			o_rd_en        <= 1'b0;
			rd_outstanding <= 1'b0;
			oy             <= '0;
			ox             <= '0;
			wy             <= '0;
			wx             <= '0;
		end else begin
			o_rd_en <= 1'b0;  // One pulse per burst
			if (o_rd_en)
				rd_outstanding <= 1'b1;
			else if (i_atom_valid)
				rd_outstanding <= 1'b0;
			case (state)
				st_idle: if (i_start) begin
					oy    <= '0;
					ox    <= '0;
					wy    <= '0;
					wx    <= '0;
					state <= st_req;
				end
				st_req: begin
					o_rd_en <= 1'b1;
					state   <= st_wait_atom;
				end
				st_wait_atom: if (i_atom_valid) begin
					if (o_window_last) begin
						state <= st_wait_pix;  // Hold until the writer drains
					end else begin
						state <= st_req;
						if (wx == i_kernel - 1'b1) begin
							wx <= '0;
							wy <= wy + 1'b1;
						end else
							wx <= wx + 1'b1;
					end
				end
				st_wait_pix: if (i_pixel_done) begin
					wx <= '0;
					wy <= '0;
					if (o_last_pixel) begin
						state <= st_idle;
					end else begin
						state <= st_req;
						if (ox == i_o_side - 1'b1) begin
							ox <= '0;
							oy <= oy + 1'b1;
						end else
							ox <= ox + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Address registers follow the counters above
	always_ff @(posedge clk) begin
		case (state)
			st_idle: if (i_start) begin
				row_base  <= i_data_start;
				win_base  <= i_data_start;
				rd_ptr    <= i_data_start;
				o_wr_addr <= i_result_start;
			end
			st_req: o_rd_addr <= rd_ptr;
			st_wait_atom: if (i_atom_valid && !o_window_last)
				rd_ptr <= (wx == i_kernel - 1'b1) ? rd_ptr + line_jump : rd_ptr + ATOM_WORDS;
			st_wait_pix: if (i_pixel_done && !o_last_pixel) begin
				o_wr_addr <= o_wr_addr + ATOM_WORDS;  // Results are dense, row-major
				if (ox == i_o_side - 1'b1) begin
					row_base <= row_base + row_step;
					win_base <= row_base + row_step;
					rd_ptr   <= row_base + row_step;
				end else begin
					win_base <= win_base + col_step;
					rd_ptr   <= win_base + col_step;
				end
			end
			default: ;
		endcase
	end

	a_one_burst: assert property (@(posedge clk) disable iff (rst)
		o_rd_en |-> !rd_outstanding);

endmodule

// File: src/pool_cmd_regs.sv
`timescale 1ns/1ns
`include "pool_engine_cfg.svh"

module pool_cmd_regs (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_engine_valid,
	input  pool_pkg::op_t   i_op_type,
	input  pool_pkg::side_t i_kernel,
	input  pool_pkg::side_t i_stride,
	input  pool_pkg::side_t i_i_side,
	input  pool_pkg::side_t i_o_side,
	input  pool_pkg::addr_t i_data_start_addr,
	input  pool_pkg::addr_t i_result_start_addr,
	input  logic            i_cmd_done,
	output logic            o_start,
	output pool_pkg::op_t   o_op,
	output pool_pkg::side_t o_kernel,
	output pool_pkg::side_t o_stride,
	output pool_pkg::side_t o_i_side,
	output pool_pkg::side_t o_o_side,
	output pool_pkg::addr_t o_data_start,
	output pool_pkg::addr_t o_result_start,
	output pool_pkg::side_t o_window_count,
	output logic            o_engine_ready
);
	logic busy;    // Command in progress
	logic accept;  // Host strobe taken this cycle

	assign accept = i_engine_valid && !busy;  // Strobes while busy are dropped

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy           <= 1'b0;
			o_start        <= 1'b0;
			o_engine_ready <= 1'b0;
		end else begin
			o_start <= accept;  // Kick the walker one cycle later
			if (accept) begin
				busy           <= 1'b1;
				o_engine_ready <= 1'b0;
			end else if (i_cmd_done) begin
				busy           <= 1'b0;
				o_engine_ready <= 1'b1;  // Last result word is out
			end
		end
	end

	// Layer fields, held for the whole command
	always_ff @(posedge clk) begin
		if (accept) begin
			o_op           <= i_op_type;
			o_kernel       <= i_kernel;
			o_stride       <= i_stride;
			o_i_side       <= i_i_side;
			o_o_side       <= i_o_side;
			o_data_start   <= i_data_start_addr;
			o_result_start <= i_result_start_addr;
			o_window_count <= i_kernel * i_kernel;  // Divisor for avepool
		end
	end

	a_op_legal: assert property (@(posedge clk) disable iff (rst)
		accept |-> (i_op_type inside {pool_pkg::OP_MAXPOOL, pool_pkg::OP_AVEPOOL}));

	a_kernel_range: assert property (@(posedge clk) disable iff (rst)
		accept |-> (i_kernel >= 1 && i_kernel <= `POOL_MAX_KERNEL));

	// Output side must match the geometry, no padding
	a_side_match: assert property (@(posedge clk) disable iff (rst)
		accept |-> (i_stride != '0 &&
			i_o_side == pool_pkg::side_t'((i_i_side - i_kernel) / i_stride + 1'b1)));

endmodule

// File: src/pool_pkg.sv
`include "pool_engine_cfg.svh"

package pool_pkg;

	typedef logic [`POOL_SAMPLE_W-1:0] sample_t;  // Unsigned sample

	// One pixel across the channel group, lane 0 in the low bits
	typedef sample_t [`POOL_BURST_LEN-1:0] atom_t;

	typedef logic [`POOL_ACC_W-1:0] acc_t;  // Lane max or lane sum
	typedef acc_t [`POOL_BURST_LEN-1:0] acc_atom_t;

	typedef logic [`POOL_ADDR_W-1:0] addr_t;  // DMA word address
	typedef logic [`POOL_SIDE_W-1:0] side_t;  // Sides, kernel, stride

	// Command codes as used by the host
	typedef enum logic [2:0] {
		OP_MAXPOOL = 3'd4,
		OP_AVEPOOL = 3'd5
	} op_t;

endpackage

// File: src/pool_engine_cfg.svh
`ifndef POOL_ENGINE_CFG_SVH
`define POOL_ENGINE_CFG_SVH

// Lanes per atom, also words per DMA burst
`define POOL_BURST_LEN 16

// One feature map sample
`define POOL_SAMPLE_W 16

// Lane sum width, holds 64 full-scale samples
`define POOL_ACC_W 24

// DMA word address
`define POOL_ADDR_W 30

// Sides, kernel and stride fields
`define POOL_SIDE_W 8

// Largest supported window edge
`define POOL_MAX_KERNEL 8

`endif
